// File: all.f
hdl/ex_pkg.sv
hdl/fu_result_if.sv
hdl/operand_select.sv
hdl/int_alu.sv
hdl/mult_pipe.sv
hdl/cdb_arbiter.sv
hdl/ex_stage.sv
tests/ex_stage_tb.sv

// File: hdl/cdb_arbiter.sv
// Single CDB register; the multiplier always wins and a losing ALU result waits
// in a one-entry hold. No new ALU result may arrive while alu_free is low.
`timescale 1ns/1ps
`default_nettype none

module cdb_arbiter (
	input logic clk,
	input logic reset,
	fu_result_if.dst alu_res,
	fu_result_if.dst mult_res,
	input logic alu_branch_taken,
	output logic cdb_valid,
	output ex_pkg::prf_idx_t cdb_tag,
	output ex_pkg::word_t cdb_value,
	output ex_pkg::rob_idx_t cdb_rob_idx,
	output logic branch_taken,
	output logic alu_free
);
	import ex_pkg::*;

	logic hold_valid;
	word_t hold_value;
	exec_tag_t hold_tag;
	logic hold_branch;

	////////////////////////////////////////////////////////////
	// Control
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (reset) begin
			cdb_valid <= 1'b0;
			branch_taken <= 1'b0;
			hold_valid <= 1'b0;
		end else begin
			cdb_valid <= mult_res.valid || hold_valid || alu_res.valid;
			if (mult_res.valid)
				branch_taken <= 1'b0;
			else if (hold_valid)
				branch_taken <= hold_branch;
			else
				branch_taken <= alu_res.valid && alu_branch_taken;
			// Hold fills on a collision, stays while the multiplier keeps the bus
			hold_valid <= mult_res.valid && (hold_valid || alu_res.valid);
		end
	end

	////////////////////////////////////////////////////////////
	// Bus and hold payload
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (mult_res.valid) begin
			cdb_value <= mult_res.value;
			cdb_tag <= mult_res.tag.pdest_idx;
			cdb_rob_idx <= mult_res.tag.rob_idx;
		end else if (hold_valid) begin
			cdb_value <= hold_value;
			cdb_tag <= hold_tag.pdest_idx;
			cdb_rob_idx <= hold_tag.rob_idx;
		end else begin
			cdb_value <= alu_res.value;
			cdb_tag <= alu_res.tag.pdest_idx;
			cdb_rob_idx <= alu_res.tag.rob_idx;
		end
		if (mult_res.valid && alu_res.valid) begin
			hold_value <= alu_res.value;
			hold_tag <= alu_res.tag;
			hold_branch <= alu_branch_taken;
		end
	end

	assign alu_free = !hold_valid;

	// The issue side must respect alu_free
	a_no_alu_while_held: assert property (@(posedge clk) disable iff (reset)
		hold_valid |-> !alu_res.valid);

endmodule

`default_nettype wire

// File: hdl/ex_pkg.sv
// Shared types and codes for the execute stage; data path is fixed at 64 bits.
// ALU function codes above ALU_CMPLE are undefined and yield ALU_BAD_RESULT.
`default_nettype none

package ex_pkg;

	////////////////////////////////////////////////////////////
	// Widths and basic types
	////////////////////////////////////////////////////////////
	localparam int PRF_IDX_W = 6;
	localparam int ROB_IDX_W = 5;

	typedef logic [63:0] word_t;
	typedef logic [31:0] inst_t;
	typedef logic [PRF_IDX_W-1:0] prf_idx_t;
	typedef logic [ROB_IDX_W-1:0] rob_idx_t;

	// Destination tag that follows every operation to the CDB
	typedef struct packed {
		prf_idx_t pdest_idx;
		rob_idx_t rob_idx;
	} exec_tag_t;

	////////////////////////////////////////////////////////////
	// Function and operand-source codes
	////////////////////////////////////////////////////////////
	typedef enum logic [4:0] {
		ALU_ADDQ   = 5'd0,
		ALU_SUBQ   = 5'd1,
		ALU_AND    = 5'd2,
		ALU_BIC    = 5'd3,
		ALU_BIS    = 5'd4,
		ALU_ORNOT  = 5'd5,
		ALU_XOR    = 5'd6,
		ALU_EQV    = 5'd7,
		ALU_SRL    = 5'd8,
		ALU_SLL    = 5'd9,
		ALU_SRA    = 5'd10,
		ALU_MULQ   = 5'd11,
		ALU_CMPULT = 5'd12,
		ALU_CMPEQ  = 5'd13,
		ALU_CMPULE = 5'd14,
		ALU_CMPLT  = 5'd15,
		ALU_CMPLE  = 5'd16
	} alu_func_t;

	typedef enum logic [1:0] {
		OPA_REGA     = 2'd0,
		OPA_MEM_DISP = 2'd1,
		OPA_NPC      = 2'd2,
		OPA_NOT3     = 2'd3
	} opa_sel_t;

	typedef enum logic [1:0] {
		OPB_REGB    = 2'd0,
		OPB_ALU_IMM = 2'd1,
		OPB_BR_DISP = 2'd2
	} opb_sel_t;

	localparam logic [5:0] JSR_GRP = 6'h1a;
	localparam word_t ALU_BAD_RESULT = 64'hdeadbeefbaadbeef;

endpackage

`default_nettype wire

// File: hdl/ex_stage.sv
// Single-issue execute stage: ALU results reach the CDB one cycle after issue,
// multiplies MULT_STAGES+1 cycles after issue. Legal MULT_STAGES are 2, 4 and 8.
`timescale 1ns/1ps
`default_nettype none

module ex_stage #(
	parameter int MULT_STAGES = 8
) (
	input logic clk,
	input logic reset,
	input logic issue_valid,
	input ex_pkg::alu_func_t alu_func,
	input ex_pkg::inst_t inst,
	input ex_pkg::word_t npc,
	input ex_pkg::word_t rega_value,
	input ex_pkg::word_t regb_value,
	input ex_pkg::prf_idx_t pdest_idx,
	input ex_pkg::rob_idx_t rob_idx,
	output logic cdb_valid,
	output ex_pkg::prf_idx_t cdb_tag,
	output ex_pkg::word_t cdb_value,
	output ex_pkg::rob_idx_t cdb_rob_idx,
	output logic branch_taken,
	output logic alu_free
);
	import ex_pkg::*;

	word_t opa;
	word_t opb;
	logic alu_valid;
	logic mult_start;
	logic alu_branch_taken;
	exec_tag_t issue_tag;

	fu_result_if alu_res ();
	fu_result_if mult_res ();

	assign issue_tag = '{pdest_idx: pdest_idx, rob_idx: rob_idx};

	operand_select operand_select_inst (
		.issue_valid(issue_valid),
		.alu_func(alu_func),
		.inst(inst),
		.npc(npc),
		.rega_value(rega_value),
		.regb_value(regb_value),
		.opa(opa),
		.opb(opb),
		.alu_valid(alu_valid),
		.mult_start(mult_start)
	);

	int_alu int_alu_inst (
		.opa(opa),
		.opb(opb),
		.alu_func(alu_func),
		.inst(inst),
		.rega_value(rega_value),
		.alu_valid(alu_valid),
		.tag(issue_tag),
		.res(alu_res.src),
		.branch_taken(alu_branch_taken)
	);

	mult_pipe #(
		.MULT_STAGES(MULT_STAGES)
	) mult_pipe_inst (
		.clk(clk),
		.reset(reset),
		.start(mult_start),
		.mcand(opa),
		.mplier(opb),
		.tag(issue_tag),
		.res(mult_res.src)
	);

	cdb_arbiter cdb_arbiter_inst (
		.clk(clk),
		.reset(reset),
		.alu_res(alu_res.dst),
		.mult_res(mult_res.dst),
		.alu_branch_taken(alu_branch_taken),
		.cdb_valid(cdb_valid),
		.cdb_tag(cdb_tag),
		.cdb_value(cdb_value),
		.cdb_rob_idx(cdb_rob_idx),
		.branch_taken(branch_taken),
		.alu_free(alu_free)
	);

endmodule

`default_nettype wire

// File: hdl/fu_result_if.sv
// Finished result of one functional unit; no acknowledge, valid qualifies the rest
`timescale 1ns/1ps
`default_nettype none

interface fu_result_if;
	import ex_pkg::*;

	logic valid;
	word_t value;
	exec_tag_t tag;

	// Functional unit side
	modport src (
		output valid,
		output value,
		output tag
	);

	// Bus register side
	modport dst (
		input valid,
		input value,
		input tag
	);

endinterface

`default_nettype wire

// File: hdl/int_alu.sv
// Combinational integer ALU plus branch condition; MULQ is handled by mult_pipe.
`timescale 1ns/1ps
`default_nettype none

module int_alu (
	input ex_pkg::word_t opa,
	input ex_pkg::word_t opb,
	input ex_pkg::alu_func_t alu_func,
	input ex_pkg::inst_t inst,
	input ex_pkg::word_t rega_value,
	input logic alu_valid,
	input ex_pkg::exec_tag_t tag,
	fu_result_if.src res,
	output logic branch_taken
);
	import ex_pkg::*;

	word_t result;
	logic [6:0] sra_fill_shift;
	logic cond;

	// Equal signs compare as unsigned, otherwise the negative one is smaller
	function automatic logic signed_lt(input word_t a, input word_t b);
		if (a[63] == b[63])
			return a < b;
		return a[63];
	endfunction

	////////////////////////////////////////////////////////////
	// Function evaluation
	////////////////////////////////////////////////////////////
	assign sra_fill_shift = 7'd64 - {1'b0, opb[5:0]};

	always_comb begin
		case (alu_func)
			ALU_ADDQ: result = opa + opb;
			ALU_SUBQ: result = opa - opb;
			ALU_AND: result = opa & opb;
			ALU_BIC: result = opa & ~opb;
			ALU_BIS: result = opa | opb;
			ALU_ORNOT: result = opa | ~opb;
			ALU_XOR: result = opa ^ opb;
			ALU_EQV: result = opa ^ ~opb;
			ALU_SRL: result = opa >> opb[5:0];
			ALU_SLL: result = opa << opb[5:0];
			// Sign fill shifted in from the top; a zero shift leaves no fill
			ALU_SRA: result = (opa >> opb[5:0]) | ({64{opa[63]}} << sra_fill_shift);
			ALU_CMPULT: result = {63'd0, opa < opb};
			ALU_CMPEQ: result = {63'd0, opa == opb};
			ALU_CMPULE: result = {63'd0, opa <= opb};
			ALU_CMPLT: result = {63'd0, signed_lt(opa, opb)};
			ALU_CMPLE: result = {63'd0, signed_lt(opa, opb) || (opa == opb)};
			// MULQ never arrives with alu_valid set
			default: result = ALU_BAD_RESULT;
		endcase
	end

	assign res.valid = alu_valid;
	assign res.value = result;
	assign res.tag = tag;

	////////////////////////////////////////////////////////////
	// Branch condition on regA, code in inst[28:26]
	////////////////////////////////////////////////////////////
	always_comb begin
		case (inst[27:26])
			2'b00: cond = !rega_value[0];
			2'b01: cond = (rega_value == 64'd0);
			2'b10: cond = rega_value[63];
			default: cond = rega_value[63] || (rega_value == 64'd0);
		endcase
		if (inst[28])
			cond = !cond;
	end

	assign branch_taken = (inst[31:30] == 2'b11) && cond;

endmodule

`default_nettype wire

// File: hdl/mult_pipe.sv
// Pipelined 64x64 multiplier, low 64 bits of the product, no stall.
// MULT_STAGES must divide 64; one new multiply may start every cycle.
`timescale 1ns/1ps
`default_nettype none

module mult_pipe #(
	parameter int MULT_STAGES = 8
) (
	input logic clk,
	input logic reset,
	input logic start,
	input ex_pkg::word_t mcand,
	input ex_pkg::word_t mplier,
	input ex_pkg::exec_tag_t tag,
	fu_result_if.src res
);
	import ex_pkg::*;

	localparam int BITS = 64 / MULT_STAGES;

	// Index 0 is the pipe input, index MULT_STAGES the last stage
	word_t prod_q [MULT_STAGES+1];
	word_t mcand_q [MULT_STAGES+1];
	word_t mplier_q [MULT_STAGES+1];
	exec_tag_t tag_q [MULT_STAGES+1];
	logic valid_q [MULT_STAGES+1];

	assign prod_q[0] = '0;
	assign mcand_q[0] = mcand;
	assign mplier_q[0] = mplier;
	assign tag_q[0] = tag;
	assign valid_q[0] = start;

	////////////////////////////////////////////////////////////
	// Stages
	////////////////////////////////////////////////////////////
	for (genvar s = 0; s < MULT_STAGES; s++) begin : g_stage
		word_t partial;

		// Low BITS of the multiplier times the aligned multiplicand
		assign partial = word_t'(mplier_q[s][BITS-1:0]) * mcand_q[s];

		always_ff @(posedge clk) begin
			prod_q[s+1] <= prod_q[s] + partial;
			mcand_q[s+1] <= mcand_q[s] << BITS;
			mplier_q[s+1] <= mplier_q[s] >> BITS;
			tag_q[s+1] <= tag_q[s];
		end

		always_ff @(posedge clk) begin
			if (reset)
				valid_q[s+1] <= 1'b0;
			else
				valid_q[s+1] <= valid_q[s];
		end
	end

	assign res.valid = valid_q[MULT_STAGES];
	assign res.value = prod_q[MULT_STAGES];
	assign res.tag = tag_q[MULT_STAGES];

	a_stage_split: assert property (@(posedge clk) (64 % MULT_STAGES) == 0)
		else $error("MULT_STAGES must divide 64");

endmodule

`default_nettype wire

// File: hdl/operand_select.sv
// Operand decode for the execute stage, purely combinational.
// MULQ goes to the multiplier, every other function to the ALU.
`timescale 1ns/1ps
`default_nettype none

module operand_select (
	input logic issue_valid,
	input ex_pkg::alu_func_t alu_func,
	input ex_pkg::inst_t inst,
	input ex_pkg::word_t npc,
	input ex_pkg::word_t rega_value,
	input ex_pkg::word_t regb_value,
	output ex_pkg::word_t opa,
	output ex_pkg::word_t opb,
	output logic alu_valid,
	output logic mult_start
);
	import ex_pkg::*;

	word_t mem_disp;
	word_t br_disp;
	word_t alu_imm;
	opa_sel_t opa_sel;
	opb_sel_t opb_sel;
	logic is_mulq;

	////////////////////////////////////////////////////////////
	// Immediates
	////////////////////////////////////////////////////////////
	assign mem_disp = {{48{inst[15]}}, inst[15:0]};
	// Branch displacement counts words
	assign br_disp = {{41{inst[20]}}, inst[20:0], 2'b00};
	assign alu_imm = {56'b0, inst[20:13]};

	////////////////////////////////////////////////////////////
	// Source decode from the opcode group
	////////////////////////////////////////////////////////////
	always_comb begin
		opa_sel = OPA_REGA;
		opb_sel = OPB_REGB;
		case (inst[31:29])
			3'b010: begin
				// Operate format, bit 12 picks the literal
				opb_sel = inst[12] ? OPB_ALU_IMM : OPB_REGB;
			end
			3'b011: begin
				if (inst[31:26] == JSR_GRP)
					opa_sel = OPA_NOT3;
			end
			3'b001, 3'b100, 3'b101: begin
				opa_sel = OPA_MEM_DISP;
			end
			3'b110, 3'b111: begin
				opa_sel = OPA_NPC;
				opb_sel = OPB_BR_DISP;
			end
			default: begin
				opa_sel = OPA_REGA;
			end
		endcase
	end

	always_comb begin
		case (opa_sel)
			OPA_MEM_DISP: opa = mem_disp;
			OPA_NPC: opa = npc;
			OPA_NOT3: opa = ~64'h3;
			default: opa = rega_value;
		endcase
		case (opb_sel)
			OPB_ALU_IMM: opb = alu_imm;
			OPB_BR_DISP: opb = br_disp;
			default: opb = regb_value;
		endcase
	end

	// Steer the issue to exactly one unit
	assign is_mulq = (alu_func == ALU_MULQ);
	assign mult_start = issue_valid && is_mulq;
	assign alu_valid = issue_valid && !is_mulq;

endmodule

`default_nettype wire

// File: run.sh
#!/usr/bin/env bash
# Build and run the execute-stage testbench with Verilator, then search the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module ex_stage_tb -f all.f -o ex_stage_sim \
	&& ./obj_dir/ex_stage_sim > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "Build or run error"; exit 1; }
cat sim.log
grep -q "^Simulation completed successfully$" sim.log && exit 0 || exit 1

// File: tests/ex_stage_tb.sv
// Testbench for ex_stage with MULT_STAGES fixed at 8; results are matched by CDB tag.
// The entry after a collision needs a gap of one cycle so the hold can be seen.
`timescale 1ns/1ps
`default_nettype none

module ex_stage_tb;
	import ex_pkg::*;

	localparam int MULT_STAGES = 8;
	localparam int MULT_LAT = MULT_STAGES + 1;
	localparam int MAX_ENTRIES = 40;
	localparam inst_t OPR = 32'h4000_0000;

	logic clk;
	logic reset;
	logic issue_valid;
	alu_func_t alu_func;
	inst_t inst;
	word_t npc;
	word_t rega_value;
	word_t regb_value;
	prf_idx_t pdest_idx;
	rob_idx_t rob_idx;
	logic cdb_valid;
	prf_idx_t cdb_tag;
	word_t cdb_value;
	rob_idx_t cdb_rob_idx;
	logic branch_taken;
	logic alu_free;

	// Stimulus table with expected results
	logic [4:0] tab_func [MAX_ENTRIES];
	inst_t tab_inst [MAX_ENTRIES];
	word_t tab_npc [MAX_ENTRIES];
	word_t tab_rega [MAX_ENTRIES];
	word_t tab_regb [MAX_ENTRIES];
	word_t tab_exp [MAX_ENTRIES];
	logic tab_br [MAX_ENTRIES];
	int tab_gap [MAX_ENTRIES];
	int tab_lat [MAX_ENTRIES];
	int issue_cycle [MAX_ENTRIES];
	logic got [MAX_ENTRIES];
	int n_entries = 0;

	logic [31:0] lfsr_state = 32'ha0f5;
	int cycle = 0;
	int received = 0;
	int passed = 0;
	int failed = 0;
	int errors = 0;
	logic saw_hold = 1'b0;
	logic reset_ok = 1'b1;

	ex_stage #(
		.MULT_STAGES(MULT_STAGES)
	) ex_stage_inst (
		.clk(clk),
		.reset(reset),
		.issue_valid(issue_valid),
		.alu_func(alu_func),
		.inst(inst),
		.npc(npc),
		.rega_value(rega_value),
		.regb_value(regb_value),
		.pdest_idx(pdest_idx),
		.rob_idx(rob_idx),
		.cdb_valid(cdb_valid),
		.cdb_tag(cdb_tag),
		.cdb_value(cdb_value),
		.cdb_rob_idx(cdb_rob_idx),
		.branch_taken(branch_taken),
		.alu_free(alu_free)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(posedge clk) cycle <= cycle + 1;

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic draw_word(output word_t w);
		for (int k = 0; k < 64; k++) begin
			lfsr_state = lfsr_step(lfsr_state);
			w = {w[62:0], lfsr_state[0]};
		end
	endtask

	task automatic add_entry(input logic [4:0] func, input inst_t iw, input word_t pc,
			input word_t a, input word_t b, input word_t exp, input logic br,
			input int gap, input int lat);
		tab_func[n_entries] = func;
		tab_inst[n_entries] = iw;
		tab_npc[n_entries] = pc;
		tab_rega[n_entries] = a;
		tab_regb[n_entries] = b;
		tab_exp[n_entries] = exp;
		tab_br[n_entries] = br;
		tab_gap[n_entries] = gap;
		tab_lat[n_entries] = lat;
		got[n_entries] = 1'b0;
		n_entries++;
	endtask

	task automatic report_mismatch(input string name, input word_t exp, input word_t act);
		$display("[ERROR] %0t %s expected %h got %h", $time, name, exp, act);
		errors++;
	endtask

	////////////////////////////////////////////////////////////
	// Table
	////////////////////////////////////////////////////////////
	task automatic build_table();
		word_t ma;
		word_t mb;
		add_entry(ALU_ADDQ, OPR, 0, 64'd5, 64'd3, 64'd8, 0, 0, 1);
		add_entry(ALU_SUBQ, OPR, 0, 64'd3, 64'd5, 64'hffff_ffff_ffff_fffe, 0, 0, 1);
		add_entry(ALU_AND, OPR, 0, 64'hf0f0, 64'hff00, 64'hf000, 0, 0, 1);
		add_entry(ALU_BIC, OPR, 0, 64'hf0f0, 64'hff00, 64'h00f0, 0, 0, 1);
		add_entry(ALU_BIS, OPR, 0, 64'hf0f0, 64'h0f0f, 64'hffff, 0, 0, 1);
		add_entry(ALU_ORNOT, OPR, 0, 64'd0, 64'hffff_ffff_ffff_0000, 64'hffff, 0, 0, 1);
		add_entry(ALU_XOR, OPR, 0, 64'hff, 64'h0f, 64'hf0, 0, 0, 1);
		add_entry(ALU_EQV, OPR, 0, 64'hff, 64'h0f, 64'hffff_ffff_ffff_ff0f, 0, 0, 1);
		add_entry(ALU_SRL, OPR, 0, 64'h8000_0000_0000_0000, 64'd4, 64'h0800_0000_0000_0000, 0, 0, 1);
		add_entry(ALU_SLL, OPR, 0, 64'd1, 64'd63, 64'h8000_0000_0000_0000, 0, 0, 1);
		add_entry(ALU_SRA, OPR, 0, 64'h8000_0000_0000_0000, 64'd4, 64'hf800_0000_0000_0000, 0, 0, 1);
		add_entry(ALU_CMPULT, OPR, 0, 64'd1, 64'hffff_ffff_ffff_ffff, 64'd1, 0, 0, 1);
		add_entry(ALU_CMPEQ, OPR, 0, 64'd7, 64'd7, 64'd1, 0, 0, 1);
		add_entry(ALU_CMPULE, OPR, 0, 64'd8, 64'd7, 64'd0, 0, 0, 1);
		add_entry(ALU_CMPLT, OPR, 0, 64'hffff_ffff_ffff_ffff, 64'd1, 64'd1, 0, 0, 1);
		add_entry(ALU_CMPLE, OPR, 0, 64'd1, 64'hffff_ffff_ffff_ffff, 64'd0, 0, 0, 1);
		add_entry(5'd17, OPR, 0, 64'd1, 64'd2, ALU_BAD_RESULT, 0, 0, 1);
		// Literal, memory displacement and JSR address forms
		add_entry(ALU_ADDQ, 32'h4015_7000, 0, 64'h10, 64'hffff, 64'hbb, 0, 0, 1);
		add_entry(ALU_ADDQ, 32'h2000_fff0, 0, 64'd0, 64'h100, 64'hf0, 0, 0, 1);
		add_entry(ALU_AND, 32'h6800_0000, 0, 64'd0, 64'h1237, 64'h1234, 0, 0, 1);
		// Branches, one per condition code
		add_entry(ALU_ADDQ, 32'he01f_fffe, 64'h1000, 64'd2, 64'd0, 64'hff8, 1, 0, 1);
		add_entry(ALU_ADDQ, 32'he41f_fffe, 64'h1000, 64'd0, 64'd0, 64'hff8, 1, 0, 1);
		add_entry(ALU_ADDQ, 32'he81f_fffe, 64'h1000, 64'd5, 64'd0, 64'hff8, 0, 0, 1);
		add_entry(ALU_ADDQ, 32'hec1f_fffe, 64'h1000, 64'h8000_0000_0000_0000, 64'd0, 64'hff8,
			1, 0, 1);
		add_entry(ALU_ADDQ, 32'hf01f_fffe, 64'h1000, 64'd2, 64'd0, 64'hff8, 0, 0, 1);
		add_entry(ALU_ADDQ, 32'hf41f_fffe, 64'h1000, 64'd0, 64'd0, 64'hff8, 0, 0, 1);
		add_entry(ALU_ADDQ, 32'hf81f_fffe, 64'h1000, 64'd5, 64'd0, 64'hff8, 1, 0, 1);
		add_entry(ALU_ADDQ, 32'hfc00_0004, 64'h1000, 64'd1, 64'd0, 64'h1010, 1, 0, 1);
		// Two back-to-back multiplies, then an ALU op landing on the first one
		draw_word(ma);
		draw_word(mb);
		add_entry(ALU_MULQ, OPR, 0, ma, mb, ma * mb, 0, 0, MULT_LAT);
		draw_word(ma);
		draw_word(mb);
		add_entry(ALU_MULQ, OPR, 0, ma, mb, ma * mb, 0, 0, MULT_LAT);
		add_entry(ALU_XOR, OPR, 0, 64'haaaa, 64'h5555, 64'hffff, 0, MULT_STAGES - 2, 3);
		add_entry(ALU_BIS, OPR, 0, 64'd0, 64'd1, 64'd1, 0, 1, 1);
	endtask

	////////////////////////////////////////////////////////////
	// Driver
	////////////////////////////////////////////////////////////
	initial begin
		reset = 1'b1;
		issue_valid = 1'b0;
		alu_func = ALU_ADDQ;
		inst = '0;
		npc = '0;
		rega_value = '0;
		regb_value = '0;
		pdest_idx = '0;
		rob_idx = '0;
		build_table();

		repeat (4) begin
			@(negedge clk);
			if (cdb_valid !== 1'b0 || alu_free !== 1'b1)
				reset_ok = 1'b0;
		end
		@(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		if (cdb_valid !== 1'b0 || alu_free !== 1'b1)
			reset_ok = 1'b0;
		if (!reset_ok)
			$display("[ERROR] %0t cdb_valid or alu_free wrong around reset", $time);
		$display("Reset test: %s", reset_ok ? "pass" : "FAIL");
		if (!reset_ok)
			errors++;

		for (int i = 0; i < n_entries; i++) begin
			repeat (tab_gap[i]) begin
				@(posedge clk);
				issue_valid <= 1'b0;
			end
			if (tab_func[i] != ALU_MULQ) begin
				@(negedge clk);
				while (!alu_free) begin
					@(posedge clk);
					issue_valid <= 1'b0;
					@(negedge clk);
				end
			end
			@(posedge clk);
			issue_valid <= 1'b1;
			alu_func <= alu_func_t'(tab_func[i]);
			inst <= tab_inst[i];
			npc <= tab_npc[i];
			rega_value <= tab_rega[i];
			regb_value <= tab_regb[i];
			pdest_idx <= prf_idx_t'(i + 1);
			rob_idx <= rob_idx_t'(i);
			issue_cycle[i] = cycle + 1;
		end
		@(posedge clk);
		issue_valid <= 1'b0;

		while (received < n_entries)
			@(negedge clk);
		// A few more cycles to catch duplicate broadcasts
		repeat (3) @(posedge clk);
		if (!saw_hold) begin
			$display("alu_free never went low, the collision case did not happen");
			errors++;
		end
		$display("Totals: %0d entries passed, %0d failed, %0d errors", passed, failed, errors);
		if (errors == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

	////////////////////////////////////////////////////////////
	// Scoreboard
	////////////////////////////////////////////////////////////
	always @(negedge clk) begin : scoreboard
		int idx;
		int err_before;
		rob_idx_t exp_rob;
		if (!reset && !alu_free)
			saw_hold = 1'b1;
		if (!reset && cdb_valid) begin
			idx = int'(cdb_tag) - 1;
			if (idx < 0 || idx >= n_entries || got[idx]) begin
				$display("[ERROR] %0t CDB tag %0d was not expected or came twice", $time, cdb_tag);
				errors++;
			end else begin
				got[idx] = 1'b1;
				received++;
				err_before = errors;
				exp_rob = rob_idx_t'(idx);
				if (cdb_value !== tab_exp[idx])
					report_mismatch("cdb_value", tab_exp[idx], cdb_value);
				if (cdb_rob_idx !== exp_rob)
					report_mismatch("cdb_rob_idx", 64'(exp_rob), 64'(cdb_rob_idx));
				if (branch_taken !== tab_br[idx])
					report_mismatch("branch_taken", 64'(tab_br[idx]), 64'(branch_taken));
				if (cycle - issue_cycle[idx] != tab_lat[idx])
					report_mismatch("latency", 64'(tab_lat[idx]), 64'(cycle - issue_cycle[idx]));
				if (errors == err_before)
					passed++;
				else
					failed++;
				$display("Entry %0d func %0d: %s", idx, tab_func[idx],
					(errors == err_before) ? "pass" : "FAIL");
			end
		end
	end

	// Limit from the table length
	always @(negedge clk) begin
		if (cycle >= n_entries * (MULT_STAGES + 3) + 50) begin
			$display("Timeout after %0d cycles, %0d of %0d results seen",
				cycle, received, n_entries);
			$display("Simulation failed");
			$finish;
		end
	end

endmodule

`default_nettype wire
